/* Makefile */
# Verilator flow for the SlaveDaq testbench
TOP := SlaveDaqTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
source/DaqPkg.sv
source/EdgeSync.sv
source/TriggerMonitor.sv
source/AcqSequencer.sv
source/DaqStreamMux.sv
source/SlaveDaq.sv
tests/SlaveDaqTb.sv

/* source/AcqSequencer.sv */
`timescale 1ns/1ps

module AcqSequencer
	import DaqPkg::*;
#(
	parameter int TimeMinPowerReset = 8,
	parameter int TimeMinResetStart = 40,
	parameter int TimeMinSro        = 16,
	parameter int DrainTime         = 1600
) (
	input  logic                      Clk,
	input  logic                      reset_n,
	input  logic                      ModuleStart,
	input  logic [15:0]               AcquisitionTime,
	input  logic [15:0]               EndHoldTime,
	input  logic                      DataTransmitDone,
	input  logic                      TrigRise,
	input  logic                      ChipFull,
	input  logic                      ReadStart,
	input  logic                      EndRead,
	input  logic [TrigCountWidth-1:0] TrigCount,
	input  logic                      Hit,
	input  logic                      SeqReady,
	output AsicCtrl_t                 AsicCtrl,
	output PowerCtrl_t                PowerCtrl,
	output logic                      OnceEnd,
	output logic                      AllDone,
	output logic                      CountClear,
	output logic                      CountEnable,
	output logic                      HitClear,
	output logic                      RunStart,
	output StreamWord_t               SeqWord,
	output logic                      SeqValid
);

	SeqState_t                 State;
	logic [15:0]               DelayCount;   // Shared by all timed states
	logic                      ChipResetB;
	logic                      AcqOn;
	logic                      ReadoutOn;
	logic [TrigCountWidth-1:0] CountSnap;    // Count frozen for the frame words
	logic                      PowerAna;
	logic                      PowerDig;

	// Run trailer, Index 0..4
	function automatic StreamWord_t TrailerWord(input logic [2:0] Index,
		input logic [TrigCountWidth-1:0] Count);
		StreamWord_t Word;
		Word.Last = 1'b0;
		case (Index)
			3'd0:    Word.Data = PadWord;
			3'd1:    Word.Data = TailWord;
			3'd2:    Word.Data = {CountTag, Count[TrigCountWidth-1:16]};
			3'd3:    Word.Data = Count[15:0];
			default: begin
				Word.Data = EndWord;
				Word.Last = 1'b1;
			end
		endcase
		return Word;
	endfunction

	////////////////////////////////////////////////////////////
	// Run and acquisition FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			State       <= Idle;
			DelayCount  <= '0;
			ChipResetB  <= 1'b1;
			AcqOn       <= 1'b0;
			ReadoutOn   <= 1'b0;
			OnceEnd     <= 1'b0;
			AllDone     <= 1'b0;
			CountClear  <= 1'b0;
			CountEnable <= 1'b0;
			HitClear    <= 1'b0;
			RunStart    <= 1'b0;
			SeqWord     <= '0;
			SeqValid    <= 1'b0;
			CountSnap   <= '0;
		end else begin
			OnceEnd    <= 1'b0;  // Pulses by default
			CountClear <= 1'b0;
			HitClear   <= 1'b0;
			RunStart   <= 1'b0;
			case (State)
				Idle: begin
					if (ModuleStart) begin
						ChipResetB <= 1'b0;
						CountClear <= 1'b1;
						HitClear   <= 1'b1;
						RunStart   <= 1'b1;
						State      <= ChipReset;
					end
				end
				ChipReset: State <= PowerOn;
				PowerOn: begin
					if (DelayCount < TimeMinPowerReset) begin
						DelayCount <= DelayCount + 1'b1;
					end else begin
						DelayCount <= '0;
						ChipResetB <= 1'b1;
						State      <= Release;
					end
				end
				Release: begin
					if (DelayCount < TimeMinResetStart) begin
						DelayCount <= DelayCount + 1'b1;
					end else begin
						DelayCount  <= '0;
						CountEnable <= 1'b1;
						State       <= WaitStart;
					end
				end
				WaitStart: begin
					if (!ModuleStart) begin
						CountEnable <= 1'b0;
						State       <= DrainWait;
					end else if (TrigRise) begin
						AcqOn    <= 1'b1;
						HitClear <= 1'b1;
						State    <= Acquire;
					end
				end
				Acquire: begin
					// Window closes on timeout or chain full
					if (DelayCount >= AcquisitionTime || ChipFull) begin
						DelayCount <= '0;
						AcqOn      <= 1'b0;
						State      <= WaitRead;
					end else begin
						DelayCount <= DelayCount + 1'b1;
					end
				end
				WaitRead: begin
					if (ReadStart) begin
						ReadoutOn <= 1'b1;
						State     <= StartRead;
					end
				end
				StartRead: begin
					if (DelayCount < TimeMinSro) begin
						DelayCount <= DelayCount + 1'b1;
					end else begin
						DelayCount <= '0;
						ReadoutOn  <= 1'b0;
						State      <= WaitReadDone;
					end
				end
				WaitReadDone: if (EndRead) State <= OnceEndHold;
				OnceEndHold: begin
					if (DelayCount < EndHoldTime) begin
						DelayCount <= DelayCount + 1'b1;
					end else if (Hit) begin
						DelayCount   <= '0;
						CountSnap    <= TrigCount;
						SeqWord.Data <= {TrigIdTag, TrigCount[TrigCountWidth-1:16]};
						SeqWord.Last <= 1'b0;
						SeqValid     <= 1'b1;
						State        <= PushTrigHigh;
					end else begin
						DelayCount <= '0;
						OnceEnd    <= 1'b1;  // Empty readout, no trigger ID
						State      <= WaitStart;
					end
				end
				PushTrigHigh: begin
					if (SeqReady) begin
						SeqWord.Data <= CountSnap[15:0];
						State        <= PushTrigLow;
					end
				end
				PushTrigLow: begin
					if (SeqReady) begin
						SeqValid <= 1'b0;
						OnceEnd  <= 1'b1;
						State    <= WaitStart;
					end
				end
				DrainWait: begin
					if (DelayCount < DrainTime) begin
						DelayCount <= DelayCount + 1'b1;
					end else begin
						DelayCount <= '0;
						CountSnap  <= TrigCount;
						SeqWord    <= TrailerWord(3'd0, TrigCount);
						SeqValid   <= 1'b1;
						State      <= PushTrailer;
					end
				end
				PushTrailer: begin
					// DelayCount walks the trailer word index
					if (SeqReady) begin
						if (DelayCount == 16'd4) begin
							DelayCount <= '0;
							SeqValid   <= 1'b0;
							AllDone    <= 1'b1;
							State      <= AllDoneWait;
						end else begin
							DelayCount <= DelayCount + 1'b1;
							SeqWord    <= TrailerWord(DelayCount[2:0] + 3'd1, CountSnap);
						end
					end
				end
				AllDoneWait: begin
					if (DataTransmitDone) begin
						AllDone <= 1'b0;
						State   <= Idle;
					end
				end
				default: State <= Idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Chip control and power pulsing
	////////////////////////////////////////////////////////////
	assign PowerAna = (State >= ChipReset) && (State <= PushTrigLow);
	assign PowerDig = (State >= PowerOn) && (State <= PushTrigLow);

	assign PowerCtrl = '{PwrOnA: PowerAna, PwrOnD: PowerDig, PwrOnDac: PowerAna};
	assign AsicCtrl  = '{ResetB: ChipResetB, StartAcq: AcqOn,
		ForceExternalRaz: ~AcqOn, StartReadout: ReadoutOn};  // Raz forced outside the window

endmodule

/* source/DaqPkg.sv */
package DaqPkg;

	////////////////////////////////////////////////////////////
	// Sequencer states
	////////////////////////////////////////////////////////////
	// PwrOnA and PwrOnDac cover the range ChipReset..PushTrigLow
	// PwrOnD covers PowerOn..PushTrigLow
	typedef enum logic [4:0] {
		Idle,
		ChipReset,
		PowerOn,
		Release,
		WaitStart,
		Acquire,
		WaitRead,
		StartRead,
		WaitReadDone,
		OnceEndHold,
		PushTrigHigh,
		PushTrigLow,
		DrainWait,
		PushTrailer,
		AllDoneWait
	} SeqState_t;

	////////////////////////////////////////////////////////////
	// Stream and control bundles
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [15:0] Data;
		logic        Last;  // Final trailer word only
	} StreamWord_t;

	typedef struct packed {
		logic ResetB;            // Chip digital reset, active low
		logic StartAcq;
		logic ForceExternalRaz;
		logic StartReadout;
	} AsicCtrl_t;

	typedef struct packed {
		logic PwrOnA;    // Analogue
		logic PwrOnD;    // Digital
		logic PwrOnDac;
	} PowerCtrl_t;

	// Frame markers
	localparam logic [7:0]  TrigIdTag = 8'hF1;
	localparam logic [7:0]  CountTag  = 8'hCC;
	localparam logic [15:0] TailWord  = 16'hFF45;
	localparam logic [15:0] EndWord   = 16'h45FF;
	localparam logic [15:0] PadWord   = 16'h0000;

	localparam int TrigCountWidth = 24;

endpackage

/* source/DaqStreamMux.sv */
`timescale 1ns/1ps

module DaqStreamMux
	import DaqPkg::*;
#(
	parameter int FifoDepth = 16
) (
	input  logic        Clk,
	input  logic        reset_n,
	input  logic [15:0] AsicData,
	input  logic        AsicValid,
	input  StreamWord_t SeqWord,
	input  logic        SeqValid,
	input  logic        RunStart,
	input  logic        OutReady,
	output logic        SeqReady,
	output StreamWord_t OutWord,
	output logic        OutValid,
	output logic        Overflow
);

	localparam int AddrWidth  = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
	localparam int LevelWidth = $clog2(FifoDepth + 1);

	StreamWord_t           Mem [FifoDepth];
	logic [AddrWidth-1:0]  WrPtr;
	logic [AddrWidth-1:0]  RdPtr;
	logic [LevelWidth-1:0] Level;
	logic                  Full;
	logic                  Push;
	logic                  Pop;
	StreamWord_t           WrWord;

	function automatic logic [AddrWidth-1:0] NextPtr(input logic [AddrWidth-1:0] Ptr);
		return (Ptr == AddrWidth'(FifoDepth - 1)) ? '0 : Ptr + 1'b1;
	endfunction

	assign Full     = (Level == LevelWidth'(FifoDepth));
	assign SeqReady = ~Full & ~AsicValid;  // ASIC words cannot wait
	assign Push     = ~Full & (AsicValid | SeqValid);
	assign WrWord   = AsicValid ? StreamWord_t'{Data: AsicData, Last: 1'b0} : SeqWord;
	assign OutValid = (Level != '0);
	assign Pop      = OutValid & OutReady;
	assign OutWord  = Mem[RdPtr];  // Head of FIFO

	always_ff @(posedge Clk) begin
		if (Push) Mem[WrPtr] <= WrWord;
	end

	////////////////////////////////////////////////////////////
	// Pointers, level, overflow
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			WrPtr <= '0;
			RdPtr <= '0;
			Level <= '0;
		end else begin
			if (Push) WrPtr <= NextPtr(WrPtr);
			if (Pop) RdPtr <= NextPtr(RdPtr);
			case ({Push, Pop})
				2'b10:   Level <= Level + 1'b1;
				2'b01:   Level <= Level - 1'b1;
				default: Level <= Level;
			endcase
		end
	end

	// Sticky until the next run
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			Overflow <= 1'b0;
		end else if (RunStart) begin
			Overflow <= 1'b0;
		end else if (AsicValid && Full) begin
			Overflow <= 1'b1;
		end
	end

endmodule

/* source/EdgeSync.sv */
`timescale 1ns/1ps

module EdgeSync (
	input  logic Clk,
	input  logic reset_n,
	input  logic AcqStart,
	input  logic ChipSatB,
	input  logic EndReadout,
	output logic TrigRise,
	output logic ChipFull,
	output logic ReadStart,
	output logic EndRead
);

	logic [1:0] AcqStartSync;    // [0] first stage, [1] second stage
	logic [1:0] ChipSatBSync;
	logic [1:0] EndReadoutSync;

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			AcqStartSync   <= 2'b00;
			ChipSatBSync   <= 2'b11;  // Chip idles not full
			EndReadoutSync <= 2'b00;
			TrigRise       <= 1'b0;
			ChipFull       <= 1'b0;
			ReadStart      <= 1'b0;
			EndRead        <= 1'b0;
		end else begin
			AcqStartSync   <= {AcqStartSync[0], AcqStart};
			ChipSatBSync   <= {ChipSatBSync[0], ChipSatB};
			EndReadoutSync <= {EndReadoutSync[0], EndReadout};
			// Registered edge pulses, one cycle each
			TrigRise  <= AcqStartSync[0] & ~AcqStartSync[1];
			ChipFull  <= ~ChipSatBSync[0] & ChipSatBSync[1];  // Falling, chain full
			ReadStart <= ChipSatBSync[0] & ~ChipSatBSync[1];  // Rising, readout may start
			EndRead   <= ~EndReadoutSync[0] & EndReadoutSync[1];
		end
	end

endmodule

/* source/SlaveDaq.sv */
`timescale 1ns/1ps

module SlaveDaq
	import DaqPkg::*;
#(
	parameter int TimeMinPowerReset = 8,
	parameter int TimeMinResetStart = 40,
	parameter int TimeMinSro        = 16,
	parameter int DrainTime         = 1600,
	parameter int FifoDepth         = 16
) (
	input  logic        Clk,
	input  logic        reset_n,
	// Host control
	input  logic        ModuleStart,
	input  logic [15:0] AcquisitionTime,
	input  logic [15:0] EndHoldTime,
	input  logic        DataTransmitDone,
	output logic        OnceEnd,
	output logic        AllDone,
	// Chip side, asynchronous inputs
	input  logic        AcqStart,
	input  logic        ChipSatB,
	input  logic        EndReadout,
	output AsicCtrl_t   AsicCtrl,
	output PowerCtrl_t  PowerCtrl,
	// ASIC data, no back-pressure
	input  logic [15:0] AsicData,
	input  logic        AsicValid,
	// Host stream
	output StreamWord_t OutWord,
	output logic        OutValid,
	input  logic        OutReady,
	output logic        Overflow
);

	logic                      TrigRise;
	logic                      ChipFull;
	logic                      ReadStart;
	logic                      EndRead;
	logic                      CountClear;
	logic                      CountEnable;
	logic                      HitClear;
	logic                      RunStart;
	logic [TrigCountWidth-1:0] TrigCount;
	logic                      Hit;
	StreamWord_t               SeqWord;
	logic                      SeqValid;
	logic                      SeqReady;

	EdgeSync EdgeSync_inst (
		.Clk       (Clk),
		.reset_n   (reset_n),
		.AcqStart  (AcqStart),
		.ChipSatB  (ChipSatB),
		.EndReadout(EndReadout),
		.TrigRise  (TrigRise),
		.ChipFull  (ChipFull),
		.ReadStart (ReadStart),
		.EndRead   (EndRead)
	);

	TriggerMonitor TriggerMonitor_inst (
		.Clk        (Clk),
		.reset_n    (reset_n),
		.TrigRise   (TrigRise),
		.CountClear (CountClear),
		.CountEnable(CountEnable),
		.HitClear   (HitClear),
		.AsicValid  (AsicValid),
		.TrigCount  (TrigCount),
		.Hit        (Hit)
	);

	AcqSequencer #(
		.TimeMinPowerReset(TimeMinPowerReset),
		.TimeMinResetStart(TimeMinResetStart),
		.TimeMinSro       (TimeMinSro),
		.DrainTime        (DrainTime)
	) AcqSequencer_inst (
		.Clk             (Clk),
		.reset_n         (reset_n),
		.ModuleStart     (ModuleStart),
		.AcquisitionTime (AcquisitionTime),
		.EndHoldTime     (EndHoldTime),
		.DataTransmitDone(DataTransmitDone),
		.TrigRise        (TrigRise),
		.ChipFull        (ChipFull),
		.ReadStart       (ReadStart),
		.EndRead         (EndRead),
		.TrigCount       (TrigCount),
		.Hit             (Hit),
		.SeqReady        (SeqReady),
		.AsicCtrl        (AsicCtrl),
		.PowerCtrl       (PowerCtrl),
		.OnceEnd         (OnceEnd),
		.AllDone         (AllDone),
		.CountClear      (CountClear),
		.CountEnable     (CountEnable),
		.HitClear        (HitClear),
		.RunStart        (RunStart),
		.SeqWord         (SeqWord),
		.SeqValid        (SeqValid)
	);

	DaqStreamMux #(
		.FifoDepth(FifoDepth)
	) DaqStreamMux_inst (
		.Clk      (Clk),
		.reset_n  (reset_n),
		.AsicData (AsicData),
		.AsicValid(AsicValid),
		.SeqWord  (SeqWord),
		.SeqValid (SeqValid),
		.RunStart (RunStart),
		.OutReady (OutReady),
		.SeqReady (SeqReady),
		.OutWord  (OutWord),
		.OutValid (OutValid),
		.Overflow (Overflow)
	);

endmodule

/* source/TriggerMonitor.sv */
`timescale 1ns/1ps

module TriggerMonitor
	import DaqPkg::*;
(
	input  logic                      Clk,
	input  logic                      reset_n,
	input  logic                      TrigRise,
	input  logic                      CountClear,
	input  logic                      CountEnable,
	input  logic                      HitClear,
	input  logic                      AsicValid,
	output logic [TrigCountWidth-1:0] TrigCount,
	output logic                      Hit
);

	// Run trigger counter
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			TrigCount <= '0;
		end else if (CountClear) begin
			TrigCount <= '0;
		end else if (CountEnable && TrigRise) begin
			TrigCount <= TrigCount + 1'b1;
		end
	end

	// Any ASIC word during the readout marks it as carrying hits
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			Hit <= 1'b0;
		end else if (HitClear) begin
			Hit <= 1'b0;
		end else if (AsicValid) begin
			Hit <= 1'b1;
		end
	end

endmodule

/* tests/SlaveDaqTb.sv */
`timescale 1ns/1ps

module SlaveDaqTb
	import DaqPkg::*;
();

	localparam int FifoDepth   = 16;
	localparam int DrainCycles = 64;
	localparam int PowerReset  = 8;
	localparam int ResetStart  = 40;
	localparam int AcqCycles   = 30;   // Programmed acquisition time
	localparam int HoldCycles  = 4;    // Programmed end hold time

	logic        Clk = 1'b0;
	logic        reset_n;
	logic        ModuleStart;
	logic [15:0] AcquisitionTime;
	logic [15:0] EndHoldTime;
	logic        DataTransmitDone;
	logic        OnceEnd;
	logic        AllDone;
	logic        AcqStart;
	logic        ChipSatB;
	logic        EndReadout;
	AsicCtrl_t   AsicCtrl;
	PowerCtrl_t  PowerCtrl;
	logic [15:0] AsicData;
	logic        AsicValid;
	StreamWord_t OutWord;
	logic        OutValid;
	logic        OutReady;
	logic        Overflow;

	// Stimulus table with one entry per test line
	string       Names[$];
	int          Triggers[$];
	int          WordCounts[$];
	int          HitMasks[$];
	int          EndModes[$];
	int          Backpressure[$];
	int          ExpTrigs[$];
	int          ExpWordCounts[$];

	StreamWord_t GotQ[$];         // Words accepted by the host
	string       CurName = "reset";
	int          ErrorCount = 0;
	int          Passed = 0;
	int          Failed = 0;
	int          WatchdogCycles = 0;
	int          Seed = 32'h3750c376;
	bit          HoldReady = 1'b0;
	bit          RandomReady = 1'b0;

	always #2 Clk = ~Clk;

	SlaveDaq #(
		.TimeMinPowerReset(PowerReset),
		.TimeMinResetStart(ResetStart),
		.TimeMinSro       (16),
		.DrainTime        (DrainCycles),
		.FifoDepth        (FifoDepth)
	) SlaveDaq_inst (
		.Clk             (Clk),
		.reset_n         (reset_n),
		.ModuleStart     (ModuleStart),
		.AcquisitionTime (AcquisitionTime),
		.EndHoldTime     (EndHoldTime),
		.DataTransmitDone(DataTransmitDone),
		.OnceEnd         (OnceEnd),
		.AllDone         (AllDone),
		.AcqStart        (AcqStart),
		.ChipSatB        (ChipSatB),
		.EndReadout      (EndReadout),
		.AsicCtrl        (AsicCtrl),
		.PowerCtrl       (PowerCtrl),
		.AsicData        (AsicData),
		.AsicValid       (AsicValid),
		.OutWord         (OutWord),
		.OutValid        (OutValid),
		.OutReady        (OutReady),
		.Overflow        (Overflow)
	);

	// Host collects accepted words at the falling edge where the handshake is stable
	always @(negedge Clk) begin
		if (reset_n && OutValid && OutReady) GotQ.push_back(OutWord);
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	function automatic logic [15:0] AsicPattern(input int TestIdx, input int TrigIdx,
		input int Word);
		return {TestIdx[3:0], TrigIdx[3:0], Word[7:0]};
	endfunction

	function automatic StreamWord_t MakeWord(input logic [15:0] Data, input logic Last);
		StreamWord_t Word;
		Word.Data = Data;
		Word.Last = Last;
		return Word;
	endfunction

	task automatic DriveReady();
		int R;
		R = $random(Seed);
		if (HoldReady) OutReady = 1'b0;
		else if (RandomReady) OutReady = R[0];
		else OutReady = 1'b1;
	endtask

	// All inputs change 1 ns after the rising edge
	task automatic Tick();
		@(posedge Clk);
		#1;
		DriveReady();
	endtask

	task automatic CheckValue(input string What, input logic [31:0] Expected,
		input logic [31:0] Actual);
		assert (Actual == Expected) else begin
			$display("mismatch %s %s: expected %0h, actual %0h", CurName, What, Expected, Actual);
			ErrorCount++;
		end
	endtask

	task automatic CheckTrue(input bit Cond, input string Msg);
		assert (Cond) else begin
			$display("test %s: %s", CurName, Msg);
			ErrorCount++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Run phases
	////////////////////////////////////////////////////////////
	task automatic StartRun();
		int LowCycles;
		LowCycles = 0;
		ModuleStart = 1'b1;
		while (AsicCtrl.ResetB) Tick();
		while (!AsicCtrl.ResetB) begin
			Tick();
			LowCycles++;
		end
		CheckValue("reset low cycles", PowerReset + 2, LowCycles);
		repeat (ResetStart + 4) Tick();  // Past the release time
	endtask

	task automatic RunTrigger(input int TestIdx, input int TrigIdx, input int Words,
		input bit WithData, input bit ChipFullEnd, input bit HoldLow);
		int Dur;
		int W;
		Dur = 0;
		AcqStart = 1'b1;
		repeat (2) Tick();
		AcqStart = 1'b0;
		while (!AsicCtrl.StartAcq) Tick();
		CheckValue("power during acquisition", 3'b111, PowerCtrl);
		CheckValue("Raz during acquisition", 1'b0, AsicCtrl.ForceExternalRaz);
		while (AsicCtrl.StartAcq) begin
			if (ChipFullEnd && Dur == 6) ChipSatB = 1'b0;  // Chain full
			Tick();
			Dur++;
		end
		if (ChipFullEnd) CheckTrue(Dur < AcqCycles, "StartAcq did not fall on chip full");
		else CheckValue("window length", AcqCycles + 1, Dur);
		CheckValue("Raz after acquisition", 1'b1, AsicCtrl.ForceExternalRaz);
		if (!ChipFullEnd) ChipSatB = 1'b0;
		repeat (4) Tick();
		CheckTrue(!AsicCtrl.StartReadout, "StartReadout rose while ChipSatB was low");
		ChipSatB = 1'b1;
		while (!AsicCtrl.StartReadout) Tick();
		// Chip readout emits one word per cycle and never stalls
		HoldReady = HoldLow;
		DriveReady();
		if (WithData) begin
			for (W = 0; W < Words; W++) begin
				AsicData  = AsicPattern(TestIdx, TrigIdx, W);
				AsicValid = 1'b1;
				Tick();
			end
		end
		AsicValid = 1'b0;
		while (AsicCtrl.StartReadout) Tick();
		EndReadout = 1'b1;
		repeat (2) Tick();
		EndReadout = 1'b0;
		HoldReady  = 1'b0;
		DriveReady();
		while (!OnceEnd) Tick();
		CheckValue("power at end of acquisition", 3'b111, PowerCtrl);
		Tick();
		CheckTrue(!OnceEnd, "OnceEnd lasted more than one cycle");
	endtask

	task automatic EndRun();
		ModuleStart = 1'b0;
		while (!AllDone) Tick();
		CheckValue("power after run", 3'b000, PowerCtrl);
		while (OutValid) Tick();
		repeat (3) Tick();
		CheckTrue(AllDone, "AllDone fell before DataTransmitDone");
		DataTransmitDone = 1'b1;
		Tick();
		DataTransmitDone = 1'b0;
		CheckTrue(!AllDone, "AllDone did not fall after DataTransmitDone");
	endtask

	task automatic RunTest(input int T);
		StreamWord_t               Exp[$];
		int                        ErrorsBefore;
		int                        Kept;
		int                        Mask;
		int                        Idx;
		int                        W;
		bit                        HoldLow;
		logic [TrigCountWidth-1:0] Count;

		CurName      = Names[T];
		ErrorsBefore = ErrorCount;
		Mask         = HitMasks[T];
		HoldLow      = (Backpressure[T] == 2);
		RandomReady  = (Backpressure[T] == 1);
		GotQ.delete();
		StartRun();
		for (Idx = 0; Idx < Triggers[T]; Idx++) begin
			RunTrigger(T, Idx, WordCounts[T], Mask[Idx], EndModes[T] == 1, HoldLow);
			if (Mask[Idx]) begin
				// Held-low host keeps only what the FIFO holds
				Kept = (HoldLow && WordCounts[T] > FifoDepth) ? FifoDepth : WordCounts[T];
				for (W = 0; W < Kept; W++)
					Exp.push_back(MakeWord(AsicPattern(T, Idx, W), 1'b0));
				Count = TrigCountWidth'(Idx + 1);
				Exp.push_back(MakeWord({TrigIdTag, Count[TrigCountWidth-1:16]}, 1'b0));
				Exp.push_back(MakeWord(Count[15:0], 1'b0));
			end
		end
		EndRun();
		RandomReady = 1'b0;
		Count = TrigCountWidth'(ExpTrigs[T]);
		Exp.push_back(MakeWord(PadWord, 1'b0));
		Exp.push_back(MakeWord(TailWord, 1'b0));
		Exp.push_back(MakeWord({CountTag, Count[TrigCountWidth-1:16]}, 1'b0));
		Exp.push_back(MakeWord(Count[15:0], 1'b0));
		Exp.push_back(MakeWord(EndWord, 1'b1));
		CheckValue("stream length", ExpWordCounts[T], GotQ.size());
		for (W = 0; W < Exp.size() && W < GotQ.size(); W++)
			CheckValue($sformatf("word %0d", W), Exp[W], GotQ[W]);
		CheckValue("overflow", HoldLow && WordCounts[T] > FifoDepth, Overflow);
		if (ErrorCount == ErrorsBefore) begin
			$display("test %s: ok", CurName);
			Passed++;
		end else begin
			$display("test %s: %0d errors", CurName, ErrorCount - ErrorsBefore);
			Failed++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		int    Fd;
		int    Fields;
		int    T;
		int    NTrig;
		int    NWords;
		int    Mask;
		int    Mode;
		int    Bp;
		int    ETrig;
		int    EWords;
		string Line;
		string Name;

		reset_n          = 1'b0;
		ModuleStart      = 1'b0;
		AcquisitionTime  = 16'(AcqCycles);
		EndHoldTime      = 16'(HoldCycles);
		DataTransmitDone = 1'b0;
		AcqStart         = 1'b0;
		ChipSatB         = 1'b1;
		EndReadout       = 1'b0;
		AsicData         = '0;
		AsicValid        = 1'b0;
		OutReady         = 1'b1;

		Fd = $fopen("tests/slave_daq_stimulus.txt", "r");
		if (Fd == 0) begin
			$display("cannot open the stimulus file");
			ErrorCount++;
		end else begin
			while (!$feof(Fd)) begin
				Line   = "";
				Fields = $fgets(Line, Fd);
				if (Fields > 0 && Line.getc(0) != "#") begin
					Fields = $sscanf(Line, "%s %d %d %h %d %d %d %d", Name, NTrig, NWords,
						Mask, Mode, Bp, ETrig, EWords);
					if (Fields == 8) begin
						Names.push_back(Name);
						Triggers.push_back(NTrig);
						WordCounts.push_back(NWords);
						HitMasks.push_back(Mask);
						EndModes.push_back(Mode);
						Backpressure.push_back(Bp);
						ExpTrigs.push_back(ETrig);
						ExpWordCounts.push_back(EWords);
						WatchdogCycles += NTrig * (AcqCycles + NWords + 200) + DrainCycles + 500;
					end
				end
			end
			$fclose(Fd);
		end
		if (Names.size() == 0) begin
			$display("no tests found in the stimulus file");
			ErrorCount++;
		end

		repeat (8) @(posedge Clk);
		#1;
		reset_n = 1'b1;
		Tick();
		CheckValue("AsicCtrl", 4'b1010, AsicCtrl);  // ResetB and Raz high
		CheckValue("PowerCtrl", 3'b000, PowerCtrl);
		CheckValue("status", 4'b0000, {OutValid, OnceEnd, AllDone, Overflow});
		if (ErrorCount == 0) begin
			$display("test reset: ok");
			Passed++;
		end else begin
			$display("test reset: %0d errors", ErrorCount);
			Failed++;
		end

		for (T = 0; T < Names.size(); T++) RunTest(T);

		$display("tests passed %0d, failed %0d", Passed, Failed);
		if (ErrorCount == 0 && Failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Limit grows with the number of triggers and words in the file
	initial begin
		wait (WatchdogCycles > 0);
		repeat (WatchdogCycles) @(posedge Clk);
		$display("timeout: test %s stalled", CurName);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* tests/slave_daq_stimulus.txt */
# name triggers words_per_readout hit_mask(hex, bit per readout) chip_full(1)/timeout(0)
# backpressure(0 off, 1 random, 2 hold low) expected_trigger_count expected_stream_words
basic     2  4  3  1  0  2  17
timeout   3  3  7  0  0  3  20
nodata    2  5  2  1  0  2  12
empty     1  4  0  0  0  1   5
randbp    3  6  7  1  1  3  29
overflow  1 20  1  0  2  1  23
recover   2  3  3  1  1  2  15
mixed     4  2  5  0  1  4  13
